//--- common/exec_pkg.sv
package exec_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 5;
    localparam int sel_w      = 3;
    localparam int load_w     = 3;
    localparam int store_w    = 2;

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////
    localparam logic [alu_op_w-1:0] alu_add   = 5'd0;
    localparam logic [alu_op_w-1:0] alu_sub   = 5'd1;
    localparam logic [alu_op_w-1:0] alu_sll   = 5'd2;
    localparam logic [alu_op_w-1:0] alu_slt   = 5'd3;
    localparam logic [alu_op_w-1:0] alu_sltu  = 5'd4;
    localparam logic [alu_op_w-1:0] alu_xor   = 5'd5;
    localparam logic [alu_op_w-1:0] alu_srl   = 5'd6;
    localparam logic [alu_op_w-1:0] alu_sra   = 5'd7;
    localparam logic [alu_op_w-1:0] alu_or    = 5'd8;
    localparam logic [alu_op_w-1:0] alu_and   = 5'd9;
    // lui passes the immediate straight through
    localparam logic [alu_op_w-1:0] alu_pass2 = 5'd10;
    // Branch compares
    localparam logic [alu_op_w-1:0] alu_beq   = 5'd16;
    localparam logic [alu_op_w-1:0] alu_bne   = 5'd17;
    localparam logic [alu_op_w-1:0] alu_blt   = 5'd18;
    localparam logic [alu_op_w-1:0] alu_bge   = 5'd19;
    localparam logic [alu_op_w-1:0] alu_bltu  = 5'd20;
    localparam logic [alu_op_w-1:0] alu_bgeu  = 5'd21;

    //////////////////////////////////////////////////
    // Operand select codes
    //////////////////////////////////////////////////
    localparam logic [sel_w-1:0] sel_reg = 3'd0;
    // PC on operand 1, immediate on operand 2
    localparam logic [sel_w-1:0] sel_alt = 3'd1;
    localparam logic [sel_w-1:0] sel_dm1 = 3'd2;
    localparam logic [sel_w-1:0] sel_dm2 = 3'd3;
    localparam logic [sel_w-1:0] sel_dm3 = 3'd4;
    localparam logic [sel_w-1:0] sel_wb  = 3'd5;

    // Data cache load and store codes
    localparam logic [load_w-1:0]  load_none  = 3'd0;
    localparam logic [load_w-1:0]  load_lb    = 3'd1;
    localparam logic [load_w-1:0]  load_lh    = 3'd2;
    localparam logic [load_w-1:0]  load_lw    = 3'd3;
    localparam logic [load_w-1:0]  load_lbu   = 3'd4;
    localparam logic [load_w-1:0]  load_lhu   = 3'd5;
    localparam logic [store_w-1:0] store_none = 2'd0;
    localparam logic [store_w-1:0] store_sb   = 2'd1;
    localparam logic [store_w-1:0] store_sh   = 2'd2;
    localparam logic [store_w-1:0] store_sw   = 2'd3;

endpackage

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu
    import exec_pkg::*;
#(
    parameter int DATA_W = xlen
) (
    input  logic [DATA_W-1:0]         in1,
    input  logic [DATA_W-1:0]         in2,
    input  logic [$clog2(DATA_W)-1:0] shift_amount,
    input  logic [alu_op_w-1:0]       alu_op,
    output logic [DATA_W-1:0]         result,
    output logic                      branch_taken
);

    logic              eq;
    logic              lt_s;
    logic              lt_u;
    logic              cond;
    logic              is_branch;
    logic [DATA_W-1:0] flag_word;

    // Shared compare results
    assign eq   = (in1 == in2);
    assign lt_s = ($signed(in1) < $signed(in2));
    assign lt_u = (in1 < in2);

    //////////////////////////////////////////////////
    // Branch compare
    //////////////////////////////////////////////////
    always_comb
    begin
        is_branch = 1'b1;
        cond      = 1'b0;
        case (alu_op)
            alu_beq:  cond = eq;
            alu_bne:  cond = !eq;
            alu_blt:  cond = lt_s;
            alu_bge:  cond = !lt_s;
            alu_bltu: cond = lt_u;
            alu_bgeu: cond = !lt_u;
            default:  is_branch = 1'b0;
        endcase
    end

    assign branch_taken = is_branch & cond;

    // Compare outcome placed in bit 0
    assign flag_word = {{(DATA_W-1){1'b0}}, cond};

    //////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////
    always_comb
    begin
        case (alu_op)
            alu_add:   result = in1 + in2;
            alu_sub:   result = in1 - in2;
            alu_sll:   result = in1 << shift_amount;
            alu_slt:   result = {{(DATA_W-1){1'b0}}, lt_s};
            alu_sltu:  result = {{(DATA_W-1){1'b0}}, lt_u};
            alu_xor:   result = in1 ^ in2;
            alu_srl:   result = in1 >> shift_amount;
            alu_sra:   result = $unsigned($signed(in1) >>> shift_amount);
            alu_or:    result = in1 | in2;
            alu_and:   result = in1 & in2;
            alu_pass2: result = in2;
            alu_beq,
            alu_bne,
            alu_blt,
            alu_bge,
            alu_bltu,
            alu_bgeu:  result = flag_word;
            // Unused codes give zero
            default:   result = '0;
        endcase
    end

endmodule

//--- rtl/forward_ctrl.sv
`timescale 1ns/1ps

module forward_ctrl
    import exec_pkg::*;
(
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  logic                  use_pc,
    input  logic                  use_imm,
    input  logic [reg_addr_w-1:0] dm1_rd_addr,
    input  logic                  dm1_rd_we,
    input  logic [reg_addr_w-1:0] dm2_rd_addr,
    input  logic                  dm2_rd_we,
    input  logic [reg_addr_w-1:0] dm3_rd_addr,
    input  logic                  dm3_rd_we,
    input  logic [reg_addr_w-1:0] wb_rd_addr,
    input  logic                  wb_rd_we,
    output logic [sel_w-1:0]      in1_sel,
    output logic [sel_w-1:0]      in2_sel
);

    // A younger stage matches when it writes the same non-zero register
    function automatic logic hit(
        input logic [reg_addr_w-1:0] src,
        input logic [reg_addr_w-1:0] dst,
        input logic                  we
    );
        return we && (dst == src) && (dst != '0);
    endfunction

    // Nearest stage wins, decoder override first
    function automatic logic [sel_w-1:0] pick(
        input logic [reg_addr_w-1:0] src,
        input logic                  alt
    );
        logic [sel_w-1:0] sel;
        if (alt)
            sel = sel_alt;
        else if (hit(src, dm1_rd_addr, dm1_rd_we))
            sel = sel_dm1;
        else if (hit(src, dm2_rd_addr, dm2_rd_we))
            sel = sel_dm2;
        else if (hit(src, dm3_rd_addr, dm3_rd_we))
            sel = sel_dm3;
        else if (hit(src, wb_rd_addr, wb_rd_we))
            sel = sel_wb;
        else
            sel = sel_reg;
        return sel;
    endfunction

    //////////////////////////////////////////////////
    // Operand selects
    //////////////////////////////////////////////////
    always_comb
    begin
        in1_sel = pick(rs1_addr, use_pc);
        in2_sel = pick(rs2_addr, use_imm);
    end

endmodule

//--- execution_stage/execution_stage.sv
`timescale 1ns/1ps

module execution_stage
    import exec_pkg::*;
#(
    parameter int DATA_W = xlen
) (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      clear,
    input  logic [DATA_W-1:0]         pc,
    input  logic [DATA_W-1:0]         rs1_data,
    input  logic [DATA_W-1:0]         rs2_data,
    input  logic [DATA_W-1:0]         imm,
    input  logic [DATA_W-1:0]         dm1_data,
    input  logic [DATA_W-1:0]         dm2_data,
    input  logic [DATA_W-1:0]         dm3_data,
    input  logic [DATA_W-1:0]         wb_data,
    input  logic [sel_w-1:0]          in1_sel,
    input  logic [sel_w-1:0]          in2_sel,
    input  logic [$clog2(DATA_W)-1:0] shift_amount,
    input  logic [alu_op_w-1:0]       alu_op,
    input  logic [reg_addr_w-1:0]     rd_addr_in,
    input  logic [load_w-1:0]         load_in,
    input  logic [store_w-1:0]        store_in,
    input  logic [DATA_W-1:0]         store_data_in,
    input  logic                      wb_sel_in,
    input  logic                      rd_we_in,
    output logic [reg_addr_w-1:0]     rd_addr_out,
    output logic [DATA_W-1:0]         alu_out,
    output logic                      branch_taken,
    output logic [load_w-1:0]         load_out,
    output logic [store_w-1:0]        store_out,
    output logic [DATA_W-1:0]         store_data_out,
    output logic                      wb_sel_out,
    output logic                      rd_we_out
);

    logic [DATA_W-1:0] alu_in1;
    logic [DATA_W-1:0] alu_in2;
    logic [DATA_W-1:0] alu_result;

    // Six-way operand select shared by both operands
    function automatic logic [DATA_W-1:0] operand_mux(
        input logic [sel_w-1:0]  sel,
        input logic [DATA_W-1:0] reg_val,
        input logic [DATA_W-1:0] alt_val
    );
        logic [DATA_W-1:0] val;
        case (sel)
            sel_reg: val = reg_val;
            sel_alt: val = alt_val;
            sel_dm1: val = dm1_data;
            sel_dm2: val = dm2_data;
            sel_dm3: val = dm3_data;
            sel_wb:  val = wb_data;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    //////////////////////////////////////////////////
    // Operand selection and ALU
    //////////////////////////////////////////////////
    always_comb
    begin
        alu_in1 = operand_mux(in1_sel, rs1_data, pc);
        alu_in2 = operand_mux(in2_sel, rs2_data, imm);
    end

    alu #(
        .DATA_W (DATA_W)
    ) i_alu (
        .in1          (alu_in1),
        .in2          (alu_in2),
        .shift_amount (shift_amount),
        .alu_op       (alu_op),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    //////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////
    // Control fields and result load a bubble on reset and clear
    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_addr_out <= '0;
            alu_out     <= '0;
            load_out    <= load_none;
            store_out   <= store_none;
            rd_we_out   <= 1'b0;
        end
        else if (!stall)
        begin
            if (clear)
            begin
                rd_addr_out <= '0;
                alu_out     <= '0;
                load_out    <= load_none;
                store_out   <= store_none;
                rd_we_out   <= 1'b0;
            end
            else
            begin
                rd_addr_out <= rd_addr_in;
                alu_out     <= alu_result;
                load_out    <= load_in;
                store_out   <= store_in;
                rd_we_out   <= rd_we_in;
            end
        end
    end

    // Store data and write-back select
    always_ff @(posedge CLK)
    begin
        if (!stall)
        begin
            store_data_out <= store_data_in;
            wb_sel_out     <= wb_sel_in;
        end
    end

endmodule

//--- rtl/exec_top.sv
`timescale 1ns/1ps

module exec_top
    import exec_pkg::*;
#(
    parameter int DATA_W = xlen
) (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      clear,
    input  logic [DATA_W-1:0]         pc,
    input  logic [reg_addr_w-1:0]     rs1_addr,
    input  logic [reg_addr_w-1:0]     rs2_addr,
    input  logic [reg_addr_w-1:0]     rd_addr_in,
    input  logic [DATA_W-1:0]         rs1_data,
    input  logic [DATA_W-1:0]         rs2_data,
    input  logic [DATA_W-1:0]         imm,
    input  logic [$clog2(DATA_W)-1:0] shift_amount,
    input  logic [alu_op_w-1:0]       alu_op,
    input  logic                      use_pc,
    input  logic                      use_imm,
    input  logic [load_w-1:0]         load_in,
    input  logic [store_w-1:0]        store_in,
    input  logic [DATA_W-1:0]         store_data_in,
    input  logic                      wb_sel_in,
    input  logic                      rd_we_in,
    // Younger stages
    input  logic [reg_addr_w-1:0]     dm1_rd_addr,
    input  logic                      dm1_rd_we,
    input  logic [DATA_W-1:0]         dm1_data,
    input  logic [reg_addr_w-1:0]     dm2_rd_addr,
    input  logic                      dm2_rd_we,
    input  logic [DATA_W-1:0]         dm2_data,
    input  logic [reg_addr_w-1:0]     dm3_rd_addr,
    input  logic                      dm3_rd_we,
    input  logic [DATA_W-1:0]         dm3_data,
    input  logic [reg_addr_w-1:0]     wb_rd_addr,
    input  logic                      wb_rd_we,
    input  logic [DATA_W-1:0]         wb_data,
    output logic [reg_addr_w-1:0]     rd_addr_out,
    output logic [DATA_W-1:0]         alu_out,
    output logic                      branch_taken,
    output logic [load_w-1:0]         load_out,
    output logic [store_w-1:0]        store_out,
    output logic [DATA_W-1:0]         store_data_out,
    output logic                      wb_sel_out,
    output logic                      rd_we_out
);

    logic [sel_w-1:0] in1_sel;
    logic [sel_w-1:0] in2_sel;

    //////////////////////////////////////////////////
    // Forwarding control
    //////////////////////////////////////////////////
    forward_ctrl i_forward_ctrl (
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .use_pc      (use_pc),
        .use_imm     (use_imm),
        .dm1_rd_addr (dm1_rd_addr),
        .dm1_rd_we   (dm1_rd_we),
        .dm2_rd_addr (dm2_rd_addr),
        .dm2_rd_we   (dm2_rd_we),
        .dm3_rd_addr (dm3_rd_addr),
        .dm3_rd_we   (dm3_rd_we),
        .wb_rd_addr  (wb_rd_addr),
        .wb_rd_we    (wb_rd_we),
        .in1_sel     (in1_sel),
        .in2_sel     (in2_sel)
    );

    //////////////////////////////////////////////////
    // Execute stage
    //////////////////////////////////////////////////
    execution_stage #(
        .DATA_W (DATA_W)
    ) i_execution_stage (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .stall          (stall),
        .clear          (clear),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .imm            (imm),
        .dm1_data       (dm1_data),
        .dm2_data       (dm2_data),
        .dm3_data       (dm3_data),
        .wb_data        (wb_data),
        .in1_sel        (in1_sel),
        .in2_sel        (in2_sel),
        .shift_amount   (shift_amount),
        .alu_op         (alu_op),
        .rd_addr_in     (rd_addr_in),
        .load_in        (load_in),
        .store_in       (store_in),
        .store_data_in  (store_data_in),
        .wb_sel_in      (wb_sel_in),
        .rd_we_in       (rd_we_in),
        .rd_addr_out    (rd_addr_out),
        .alu_out        (alu_out),
        .branch_taken   (branch_taken),
        .load_out       (load_out),
        .store_out      (store_out),
        .store_data_out (store_data_out),
        .wb_sel_out     (wb_sel_out),
        .rd_we_out      (rd_we_out)
    );

endmodule

//--- testbench/exec_asserts.sv
`timescale 1ns/1ps

module exec_asserts
    import exec_pkg::*;
#(
    parameter int DATA_W = xlen
) (
    input logic                  CLK,
    input logic                  rst_n,
    input logic                  stall,
    input logic                  clear,
    input logic [reg_addr_w-1:0] rd_addr_out,
    input logic [DATA_W-1:0]     alu_out,
    input logic [load_w-1:0]     load_out,
    input logic [store_w-1:0]    store_out,
    input logic                  rd_we_out
);

    // Flush without stall leaves an idle EX/MEM slot
    bubble_after_clear: assert property (@(posedge CLK) disable iff (!rst_n)
        (clear && !stall) |=> (!rd_we_out && rd_addr_out == '0 && alu_out == '0
                               && load_out == load_none && store_out == store_none))
    else $error("EX/MEM register did not take a bubble after clear");

    // Stall freezes the register, clear or not
    hold_on_stall: assert property (@(posedge CLK) disable iff (!rst_n)
        stall |=> ($stable(rd_addr_out) && $stable(alu_out) && $stable(load_out)
                   && $stable(store_out) && $stable(rd_we_out)))
    else $error("EX/MEM register changed while stalled");

    // No register write or memory access leaks out of reset
    idle_in_reset: assert property (@(posedge CLK)
        !rst_n |=> (!rd_we_out && load_out == load_none && store_out == store_none))
    else $error("EX/MEM register not idle during reset");

endmodule

bind execution_stage exec_asserts #(
    .DATA_W (DATA_W)
) i_exec_asserts (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .stall       (stall),
    .clear       (clear),
    .rd_addr_out (rd_addr_out),
    .alu_out     (alu_out),
    .load_out    (load_out),
    .store_out   (store_out),
    .rd_we_out   (rd_we_out)
);

//--- testbench/tb_exec.sv
`timescale 1ns/1ps

module tb_exec
    import exec_pkg::*;
;

    localparam int data_w         = xlen;
    localparam int clk_period_ns  = 4;
    localparam int n_op_reps      = 8;
    localparam int n_branch_rand  = 4;
    localparam int n_mix          = 300;
    localparam int total_cycles   = 5 + 18 * n_op_reps + 6 * (6 + n_branch_rand) + 40 + n_mix;
    localparam int timeout_ns     = (total_cycles + 100) * clk_period_ns;

    // Every ALU code plus one unused code
    localparam logic [alu_op_w-1:0] all_ops [18] = '{
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra, alu_or,
        alu_and, alu_pass2, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu, 5'd12
    };
    // Signed and unsigned corner pairs for the branch compares
    localparam logic [data_w-1:0] edge_a [6] = '{
        32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0001, 32'h1234_5678, 32'h0
    };
    localparam logic [data_w-1:0] edge_b [6] = '{
        32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h1234_5678, 32'h8000_0000
    };

    logic                      CLK = 1'b0;
    logic                      rst_n;
    logic                      stall;
    logic                      clear;
    logic [data_w-1:0]         pc;
    logic [reg_addr_w-1:0]     rs1_addr;
    logic [reg_addr_w-1:0]     rs2_addr;
    logic [reg_addr_w-1:0]     rd_addr_in;
    logic [data_w-1:0]         rs1_data;
    logic [data_w-1:0]         rs2_data;
    logic [data_w-1:0]         imm;
    logic [$clog2(data_w)-1:0] shift_amount;
    logic [alu_op_w-1:0]       alu_op;
    logic                      use_pc;
    logic                      use_imm;
    logic [load_w-1:0]         load_in;
    logic [store_w-1:0]        store_in;
    logic [data_w-1:0]         store_data_in;
    logic                      wb_sel_in;
    logic                      rd_we_in;
    logic [reg_addr_w-1:0]     dm1_rd_addr;
    logic                      dm1_rd_we;
    logic [data_w-1:0]         dm1_data;
    logic [reg_addr_w-1:0]     dm2_rd_addr;
    logic                      dm2_rd_we;
    logic [data_w-1:0]         dm2_data;
    logic [reg_addr_w-1:0]     dm3_rd_addr;
    logic                      dm3_rd_we;
    logic [data_w-1:0]         dm3_data;
    logic [reg_addr_w-1:0]     wb_rd_addr;
    logic                      wb_rd_we;
    logic [data_w-1:0]         wb_data;
    logic [reg_addr_w-1:0]     rd_addr_out;
    logic [data_w-1:0]         alu_out;
    logic                      branch_taken;
    logic [load_w-1:0]         load_out;
    logic [store_w-1:0]        store_out;
    logic [data_w-1:0]         store_data_out;
    logic                      wb_sel_out;
    logic                      rd_we_out;

    // Register model starting as a bubble
    logic [reg_addr_w-1:0]     exp_rd_addr    = '0;
    logic [data_w-1:0]         exp_alu        = '0;
    logic [load_w-1:0]         exp_load       = load_none;
    logic [store_w-1:0]        exp_store      = store_none;
    logic                      exp_we         = 1'b0;
    logic [data_w-1:0]         exp_store_data = '0;
    logic                      exp_wb_sel     = 1'b0;
    logic                      payload_known  = 1'b0;
    logic [31:0]               rng_state;

    exec_top #(
        .DATA_W (data_w)
    ) i_exec_top (
        .*
    );

    initial
    begin
        forever #(clk_period_ns / 2) CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Walk from WB towards DM1 so the nearest writer lands last
    function automatic logic [data_w-1:0] forward_value(
        input logic [reg_addr_w-1:0] src,
        input logic                  alt_en,
        input logic [data_w-1:0]     alt_val,
        input logic [data_w-1:0]     reg_val
    );
        logic [reg_addr_w-1:0] st_addr [4];
        logic                  st_we [4];
        logic [data_w-1:0]     st_data [4];
        logic [data_w-1:0]     val;
        int                    i;
        st_addr = '{dm1_rd_addr, dm2_rd_addr, dm3_rd_addr, wb_rd_addr};
        st_we   = '{dm1_rd_we, dm2_rd_we, dm3_rd_we, wb_rd_we};
        st_data = '{dm1_data, dm2_data, dm3_data, wb_data};
        val = reg_val;
        for (i = 3; i >= 0; i--)
        begin
            if (st_we[i] && src != '0 && st_addr[i] == src)
                val = st_data[i];
        end
        if (alt_en)
            val = alt_val;
        return val;
    endfunction

    // Branch flag on top of the ALU result
    function automatic logic [data_w:0] exec_ref();
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] res;
        logic [data_w-1:0] sign_bit;
        logic              lt_s;
        logic              cmp;
        logic              is_br;
        a        = forward_value(rs1_addr, use_pc, pc, rs1_data);
        b        = forward_value(rs2_addr, use_imm, imm, rs2_data);
        sign_bit = {1'b1, {(data_w-1){1'b0}}};
        // Signed order is unsigned order with the sign bits flipped
        lt_s     = ((a ^ sign_bit) < (b ^ sign_bit));
        cmp      = 1'b0;
        is_br    = 1'b1;
        res      = '0;
        case (alu_op)
            alu_beq:  cmp = (a == b);
            alu_bne:  cmp = (a != b);
            alu_blt:  cmp = lt_s;
            alu_bge:  cmp = !lt_s;
            alu_bltu: cmp = (a < b);
            alu_bgeu: cmp = (a >= b);
            default:  is_br = 1'b0;
        endcase
        case (alu_op)
            alu_add:   res = a + b;
            alu_sub:   res = a + ~b + 1'b1;
            alu_sll:   res = a << shift_amount;
            alu_slt:   res = {{(data_w-1){1'b0}}, lt_s};
            alu_sltu:  res = {{(data_w-1){1'b0}}, (a < b)};
            alu_xor:   res = a ^ b;
            alu_srl:   res = a >> shift_amount;
            alu_or:    res = a | b;
            alu_and:   res = a & b;
            alu_pass2: res = b;
            alu_sra:
            begin
                res = a >> shift_amount;
                if (a[data_w-1])
                    res = res | ~({data_w{1'b1}} >> shift_amount);
            end
            default:   res = {{(data_w-1){1'b0}}, cmp & is_br};
        endcase
        return {cmp & is_br, res};
    endfunction

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("[ERROR] %0.1f ns: %s", $realtime, msg);
        $display("** FAIL **");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic check_word(
        input logic [data_w-1:0] got,
        input logic [data_w-1:0] exp,
        input string             what
    );
        if (got !== exp)
            stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_ctrl(
        input logic [reg_addr_w-1:0] got_rd,
        input logic [load_w-1:0]     got_ld,
        input logic [store_w-1:0]    got_st,
        input logic                  got_we,
        input logic [reg_addr_w-1:0] exp_rd,
        input logic [load_w-1:0]     exp_ld,
        input logic [store_w-1:0]    exp_st,
        input logic                  exp_w
    );
        if (got_rd !== exp_rd || got_ld !== exp_ld || got_st !== exp_st || got_we !== exp_w)
            stop_on_error($sformatf("rd=%0d load=%0d store=%0d we=%b, expected %0d %0d %0d %b",
                got_rd, got_ld, got_st, got_we, exp_rd, exp_ld, exp_st, exp_w));
    endtask

    // Mid low phase where inputs and outputs have settled
    always @(negedge CLK)
    begin : compare
        logic [data_w:0] ref_out;
        ref_out = exec_ref();
        check_flag(branch_taken, ref_out[data_w], "branch_taken");
        check_ctrl(rd_addr_out, load_out, store_out, rd_we_out,
                   exp_rd_addr, exp_load, exp_store, exp_we);
        check_word(alu_out, exp_alu, "alu_out");
        if (payload_known)
        begin
            check_word(store_data_out, exp_store_data, "store_data_out");
            check_flag(wb_sel_out, exp_wb_sel, "wb_sel_out");
        end
        // Contents after the coming rising edge
        if (!stall)
        begin
            exp_store_data = store_data_in;
            exp_wb_sel     = wb_sel_in;
            payload_known  = 1'b1;
        end
        if (!rst_n || (!stall && clear))
        begin
            exp_rd_addr = '0;
            exp_alu     = '0;
            exp_load    = load_none;
            exp_store   = store_none;
            exp_we      = 1'b0;
        end
        else if (!stall)
        begin
            exp_rd_addr = rd_addr_in;
            exp_alu     = ref_out[data_w-1:0];
            exp_load    = load_in;
            exp_store   = store_in;
            exp_we      = rd_we_in;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge CLK);
        #0.5;
    endtask

    task automatic quiet_forwarding();
        dm1_rd_addr = '0;
        dm2_rd_addr = '0;
        dm3_rd_addr = '0;
        wb_rd_addr  = '0;
        dm1_rd_we   = 1'b0;
        dm2_rd_we   = 1'b0;
        dm3_rd_we   = 1'b0;
        wb_rd_we    = 1'b0;
        use_pc      = 1'b0;
        use_imm     = 1'b0;
    endtask

    task automatic random_instr(input logic [alu_op_w-1:0] op);
        logic [31:0] r;
        pc            = next_random();
        rs1_data      = next_random();
        rs2_data      = next_random();
        imm           = next_random();
        store_data_in = next_random();
        dm1_data      = next_random();
        dm2_data      = next_random();
        dm3_data      = next_random();
        wb_data       = next_random();
        r             = next_random();
        shift_amount  = r[$clog2(data_w)-1:0];
        rd_addr_in    = r[9:5];
        load_in       = r[12:10];
        store_in      = r[14:13];
        wb_sel_in     = r[15];
        rd_we_in      = r[16];
        rs1_addr      = r[21:17];
        rs2_addr      = r[26:22];
        alu_op        = op;
    endtask

    // Small register range so stages collide often
    task automatic random_forwarding();
        logic [31:0] r;
        r = next_random();
        dm1_rd_addr = {3'b000, r[1:0]};
        dm1_rd_we   = r[2];
        dm2_rd_addr = {3'b000, r[4:3]};
        dm2_rd_we   = r[5];
        dm3_rd_addr = {3'b000, r[7:6]};
        dm3_rd_we   = r[8];
        wb_rd_addr  = {3'b000, r[10:9]};
        wb_rd_we    = r[11];
        rs1_addr    = {3'b000, r[13:12]};
        rs2_addr    = {3'b000, r[15:14]};
        use_pc      = (r[18:16] == 3'd0);
        use_imm     = (r[21:19] == 3'd0);
    endtask

    // All four stages target dst and we_mask picks the writers
    task automatic forward_case(
        input logic [3:0]            we_mask,
        input logic [reg_addr_w-1:0] dst,
        input logic [reg_addr_w-1:0] src1,
        input logic [reg_addr_w-1:0] src2,
        input logic                  pc_en,
        input logic                  imm_en
    );
        random_instr(alu_add);
        dm1_rd_addr = dst;
        dm2_rd_addr = dst;
        dm3_rd_addr = dst;
        wb_rd_addr  = dst;
        dm1_rd_we   = we_mask[0];
        dm2_rd_we   = we_mask[1];
        dm3_rd_we   = we_mask[2];
        wb_rd_we    = we_mask[3];
        rs1_addr    = src1;
        rs2_addr    = src2;
        use_pc      = pc_en;
        use_imm     = imm_en;
        next_cycle();
    endtask

    initial
    begin
        logic [31:0] r;
        int          op_idx;
        int          k;
        rng_state = 32'hc3319156;
        rst_n     = 1'b0;
        stall     = 1'b0;
        clear     = 1'b0;
        quiet_forwarding();
        random_instr(alu_add);
        repeat (5) @(posedge CLK);
        #0.5;
        rst_n = 1'b1;

        // Each ALU code with register operands only
        for (op_idx = 0; op_idx < 18; op_idx++)
        begin
            repeat (n_op_reps)
            begin
                random_instr(all_ops[op_idx]);
                next_cycle();
            end
        end

        // Branch compares on corner pairs and random pairs
        for (op_idx = 11; op_idx < 17; op_idx++)
        begin
            for (k = 0; k < 6 + n_branch_rand; k++)
            begin
                random_instr(all_ops[op_idx]);
                if (k < 6)
                begin
                    rs1_data = edge_a[k];
                    rs2_data = edge_b[k];
                end
                next_cycle();
            end
        end

        // Forwarding cases for single stages, nearest writer, x0 and decoder override
        for (k = 0; k < 4; k++)
        begin
            forward_case(4'b0001 << k, 5'd7, 5'd7, 5'd3, 1'b0, 1'b0);
            forward_case(4'b0001 << k, 5'd7, 5'd3, 5'd7, 1'b0, 1'b0);
        end
        forward_case(4'b1111, 5'd7, 5'd7, 5'd7, 1'b0, 1'b0);
        forward_case(4'b1110, 5'd7, 5'd7, 5'd7, 1'b0, 1'b0);
        forward_case(4'b1100, 5'd7, 5'd7, 5'd7, 1'b0, 1'b0);
        forward_case(4'b1010, 5'd7, 5'd7, 5'd7, 1'b0, 1'b0);
        forward_case(4'b1111, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
        forward_case(4'b1111, 5'd7, 5'd7, 5'd7, 1'b1, 1'b1);
        forward_case(4'b1111, 5'd7, 5'd7, 5'd7, 1'b1, 1'b0);
        forward_case(4'b1111, 5'd7, 5'd7, 5'd7, 1'b0, 1'b1);
        quiet_forwarding();

        // Held stall and resume
        random_instr(alu_add);
        next_cycle();
        stall = 1'b1;
        repeat (4)
        begin
            random_instr(alu_xor);
            next_cycle();
        end
        stall = 1'b0;
        random_instr(alu_or);
        next_cycle();

        // Clear alone and clear under stall
        random_instr(alu_and);
        rd_we_in = 1'b1;
        next_cycle();
        clear = 1'b1;
        random_instr(alu_sub);
        rd_we_in = 1'b1;
        next_cycle();
        clear = 1'b0;
        random_instr(alu_add);
        rd_we_in = 1'b1;
        next_cycle();
        stall = 1'b1;
        clear = 1'b1;
        random_instr(alu_sll);
        next_cycle();
        next_cycle();
        stall = 1'b0;
        clear = 1'b0;
        random_instr(alu_sra);
        next_cycle();

        // Random mix of everything
        repeat (n_mix)
        begin
            r      = next_random();
            op_idx = int'(r % 18);
            random_instr(all_ops[op_idx]);
            random_forwarding();
            stall = (r[7:5] == 3'd0);
            clear = (r[11:8] == 4'd1);
            next_cycle();
        end
        stall = 1'b0;
        clear = 1'b0;
        next_cycle();
        next_cycle();

        $display("** PASS **");
        $finish;
    end

    initial
    begin
        #(timeout_ns);
        $display("Timeout: stimulus did not finish within %0d ns", timeout_ns);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- project.f
common/exec_pkg.sv
rtl/alu.sv
rtl/forward_ctrl.sv
execution_stage/execution_stage.sv
rtl/exec_top.sv
testbench/exec_asserts.sv
testbench/tb_exec.sv

//--- run.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it.
# The simulator exit status carries pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_exec \
    -Mdir obj_dir \
    -f project.f

./obj_dir/Vtb_exec
